//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // data path and register index widths
    localparam int xlen      = 64;
    localparam int reg_idx_w = 5;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_opimm  = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 values
    localparam logic [2:0] f3_ld    = 3'b011;
    localparam logic [2:0] f3_sd    = 3'b011;
    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;

    // fixed encodings
    localparam logic [31:0] mret_word = 32'h3020_0073;
    // addi x0, x0, 0
    localparam logic [31:0] nop_word  = 32'h0000_0013;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [6:0]           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [6:0]           opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]           imm_hi;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_lo;
        logic [6:0]           opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]          imm;
        logic [reg_idx_w-1:0] rd;
        logic [6:0]           opcode;
    } u_fmt_t;

    // one instruction word, four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } rv_instr_u;

    // operation class handed to execute
    typedef enum logic [3:0] {
        ex_nop,
        ex_lui,
        ex_addi,
        ex_add,
        ex_load,
        ex_store,
        ex_csr_rw,
        ex_csr_rs,
        ex_mret
    } exec_op_e;

endpackage

`default_nettype wire

//--- rv_csr_pkg.sv
`default_nettype none

package rv_csr_pkg;

    // machine csr addresses
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mie     = 12'h304;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;
    localparam logic [11:0] csr_mip     = 12'h344;

    // bit positions
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    // meip in mip sits at the same position
    localparam int mie_meie_bit     = 11;

    // interrupt flag plus code 11, machine external
    localparam logic [63:0] mcause_ext_irq = {1'b1, 63'd11};

    // first fetch address after reset
    localparam logic [63:0] reset_pc = 64'd44;

endpackage

`default_nettype wire

//--- rv_decode.sv
`default_nettype none

module rv_decode (
    input  rv_isa_pkg::rv_instr_u      instr,
    output rv_isa_pkg::exec_op_e       op,
    output logic [4:0]                 rd,
    output logic [4:0]                 rs1,
    output logic [4:0]                 rs2,
    output logic signed [63:0]         imm,
    output logic [11:0]                csr_addr
);
    import rv_isa_pkg::*;

    logic signed [xlen-1:0] imm_i;
    logic signed [xlen-1:0] imm_s;
    logic signed [xlen-1:0] imm_u;

    // register fields sit at fixed positions in every format
    assign rd       = instr.r_fmt.rd;
    assign rs1      = instr.r_fmt.rs1;
    assign rs2      = instr.r_fmt.rs2;
    assign csr_addr = instr.i_fmt.imm;

    // sign extended immediates
    assign imm_i = {{52{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{52{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign imm_u = {{32{instr.u_fmt.imm[19]}}, instr.u_fmt.imm, 12'b0};

    always_comb begin
        op  = ex_nop;
        imm = imm_i;
        case (instr.r_fmt.opcode)
            op_lui: begin
                op  = ex_lui;
                imm = imm_u;
            end
            op_opimm: begin
                // only addi kept
                if (instr.i_fmt.funct3 == 3'b000) begin
                    op = ex_addi;
                end
            end
            op_op: begin
                if (instr.r_fmt.funct3 == 3'b000 && instr.r_fmt.funct7 == 7'b0) begin
                    op = ex_add;
                end
            end
            op_load: begin
                if (instr.i_fmt.funct3 == f3_ld) begin
                    op = ex_load;
                end
            end
            op_store: begin
                if (instr.s_fmt.funct3 == f3_sd) begin
                    op  = ex_store;
                    imm = imm_s;
                end
            end
            op_system: begin
                if (instr == mret_word) begin
                    op = ex_mret;
                end else if (instr.i_fmt.funct3 == f3_csrrw) begin
                    op = ex_csr_rw;
                end else if (instr.i_fmt.funct3 == f3_csrrs) begin
                    op = ex_csr_rs;
                end
            end
            // anything else executes as nop
            default: op = ex_nop;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [63:0] rs1_data,
    output logic [63:0] rs2_data,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [63:0] rd_data
);

    logic [63:0] regs [0:31];

    // async reads, x0 forced to zero
    assign rs1_data = (rs1 == 5'd0) ? 64'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 64'd0;
            end
        end else if (we && rd != 5'd0) begin
            // x0 writes dropped
            regs[rd] <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- rv_csr_unit.sv
`default_nettype none

module rv_csr_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         csr_en,
    input  logic                         csr_set,
    input  logic [11:0]                  csr_addr,
    input  logic [rv_isa_pkg::xlen-1:0]  csr_wdata,
    output logic [rv_isa_pkg::xlen-1:0]  csr_rdata,
    input  logic                         ext_irq,
    output logic                         irq_take,
    input  logic                         trap,
    input  logic [rv_isa_pkg::xlen-1:0]  trap_pc,
    input  logic                         mret,
    output logic [rv_isa_pkg::xlen-1:0]  mtvec_q,
    output logic [rv_isa_pkg::xlen-1:0]  mepc_q
);
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;

    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] mie_q;
    logic [xlen-1:0] mcause_q;
    logic [xlen-1:0] mip_val;
    logic [xlen-1:0] wr_val;

    // mip is not stored, meip follows the pin
    always_comb begin
        mip_val               = '0;
        mip_val[mie_meie_bit] = ext_irq;
    end

    always_comb begin
        case (csr_addr)
            csr_mstatus: csr_rdata = mstatus_q;
            csr_mie:     csr_rdata = mie_q;
            csr_mip:     csr_rdata = mip_val;
            csr_mtvec:   csr_rdata = mtvec_q;
            csr_mepc:    csr_rdata = mepc_q;
            csr_mcause:  csr_rdata = mcause_q;
            default:     csr_rdata = '0;
        endcase
    end

    // csrrs ors into the old value, csrrw replaces it
    assign wr_val = csr_set ? (csr_rdata | csr_wdata) : csr_wdata;

    assign irq_take = mstatus_q[mstatus_mie_bit] & mie_q[mie_meie_bit] & mip_val[mie_meie_bit];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap) begin
            // trap entry, stack mie into mpie
            mepc_q                      <= trap_pc;
            mcause_q                    <= mcause_ext_irq;
            mstatus_q[mstatus_mpie_bit] <= mstatus_q[mstatus_mie_bit];
            mstatus_q[mstatus_mie_bit]  <= 1'b0;
        end else if (mret) begin
            mstatus_q[mstatus_mie_bit]  <= mstatus_q[mstatus_mpie_bit];
            mstatus_q[mstatus_mpie_bit] <= 1'b1;
        end else if (csr_en) begin
            case (csr_addr)
                csr_mstatus: mstatus_q <= wr_val;
                csr_mie:     mie_q     <= wr_val;
                csr_mtvec:   mtvec_q   <= wr_val;
                csr_mepc:    mepc_q    <= wr_val;
                csr_mcause:  mcause_q  <= wr_val;
                // mip read only here
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rv_execute.sv
`default_nettype none

module rv_execute (
    input  logic                 clk,
    input  logic                 reset,
    output logic [63:0]          pc,
    input  logic [31:0]          instruction,
    output logic [31:0]          ir_word,
    input  rv_isa_pkg::exec_op_e dec_op,
    input  logic [4:0]           dec_rd,
    input  logic [4:0]           dec_rs1,
    input  logic [4:0]           dec_rs2,
    input  logic signed [63:0]   dec_imm,
    input  logic [11:0]          dec_csr_addr,
    output logic [4:0]           rf_rs1,
    output logic [4:0]           rf_rs2,
    input  logic [63:0]          rs1_data,
    input  logic [63:0]          rs2_data,
    output logic                 rf_we,
    output logic [4:0]           rf_rd,
    output logic [63:0]          rf_wdata,
    output logic                 csr_en,
    output logic                 csr_set,
    output logic [11:0]          csr_addr,
    output logic [63:0]          csr_wdata,
    input  logic [63:0]          csr_rdata,
    input  logic                 irq_take,
    output logic                 trap,
    output logic [63:0]          trap_pc,
    output logic                 mret,
    input  logic [63:0]          mtvec_q,
    input  logic [63:0]          mepc_q,
    output logic [63:0]          bus_address,
    output logic [63:0]          bus_write_data,
    output logic                 bus_read_enable,
    output logic                 bus_write_enable,
    input  logic [63:0]          bus_read_data,
    output logic                 interrupt_ack
);
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;

    logic [xlen-1:0]      ir_pc;
    logic                 bubble;
    logic                 ld_step;
    logic [reg_idx_w-1:0] ld_rd_q;
    logic                 exec_valid;
    logic                 run;
    logic [xlen-1:0]      mem_addr;

    // ir holds a real instruction this cycle
    assign exec_valid = !bubble && !ld_step;
    // interrupt wins over the instruction in ir
    assign run        = exec_valid && !irq_take;
    assign mem_addr   = rs1_data + dec_imm;

    assign rf_rs1 = dec_rs1;
    assign rf_rs2 = dec_rs2;

    // trap strobe to csr unit, discarded instruction's pc becomes mepc
    assign trap    = exec_valid && irq_take;
    assign trap_pc = ir_pc;
    assign mret    = run && dec_op == ex_mret;

    assign csr_en    = run && (dec_op == ex_csr_rw || dec_op == ex_csr_rs);
    assign csr_set   = dec_op == ex_csr_rs;
    assign csr_addr  = dec_csr_addr;
    assign csr_wdata = rs1_data;

    // writeback select
    always_comb begin
        rf_we    = 1'b0;
        rf_rd    = dec_rd;
        rf_wdata = dec_imm;
        if (ld_step) begin
            // load step 1, read data lands now
            rf_we    = 1'b1;
            rf_rd    = ld_rd_q;
            rf_wdata = bus_read_data;
        end else if (run) begin
            case (dec_op)
                ex_lui: begin
                    rf_we = 1'b1;
                end
                ex_addi: begin
                    rf_we    = 1'b1;
                    rf_wdata = rs1_data + dec_imm;
                end
                ex_add: begin
                    rf_we    = 1'b1;
                    rf_wdata = rs1_data + rs2_data;
                end
                ex_csr_rw, ex_csr_rs: begin
                    // old csr value to rd
                    rf_we    = 1'b1;
                    rf_wdata = csr_rdata;
                end
                default: ;
            endcase
        end
    end

    // fetch register, pc and sequencing
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc               <= reset_pc;
            ir_word          <= nop_word;
            ir_pc            <= reset_pc;
            bubble           <= 1'b1;
            ld_step          <= 1'b0;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
            interrupt_ack    <= 1'b0;
        end else begin
            ir_word          <= instruction;
            ir_pc            <= pc;
            pc               <= pc + 64'd4;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
            interrupt_ack    <= trap;
            if (trap) begin
                pc     <= mtvec_q;
                bubble <= 1'b1;
            end else if (ld_step) begin
                // step 1 also drops the refetched word
                ld_step <= 1'b0;
                bubble  <= 1'b0;
            end else if (bubble) begin
                bubble <= 1'b0;
            end else begin
                case (dec_op)
                    ex_load: begin
                        // step 0, hold pc so the next word is fetched again
                        bus_read_enable <= 1'b1;
                        pc              <= pc;
                        bubble          <= 1'b1;
                        ld_step         <= 1'b1;
                    end
                    ex_store: begin
                        bus_write_enable <= 1'b1;
                    end
                    ex_mret: begin
                        pc     <= mepc_q;
                        bubble <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // bus payload and load target
    always_ff @(posedge clk) begin
        if (run && (dec_op == ex_load || dec_op == ex_store)) begin
            bus_address    <= mem_addr;
            bus_write_data <= rs2_data;
        end
        if (run && dec_op == ex_load) begin
            ld_rd_q <= dec_rd;
        end
    end

endmodule

`default_nettype wire

//--- rv64_core.sv
`default_nettype none

module rv64_core (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instruction,
    output logic [63:0] pc,
    output logic [63:0] bus_address,
    output logic [63:0] bus_write_data,
    output logic        bus_read_enable,
    output logic        bus_write_enable,
    input  logic [63:0] bus_read_data,
    input  logic        ext_irq,
    output logic        interrupt_ack
);
    import rv_isa_pkg::*;

    rv_instr_u          ir_word;
    exec_op_e           dec_op;
    logic [4:0]         dec_rd;
    logic [4:0]         dec_rs1;
    logic [4:0]         dec_rs2;
    logic signed [63:0] dec_imm;
    logic [11:0]        dec_csr_addr;

    logic [4:0]         rf_rs1;
    logic [4:0]         rf_rs2;
    logic [63:0]        rs1_data;
    logic [63:0]        rs2_data;
    logic               rf_we;
    logic [4:0]         rf_rd;
    logic [63:0]        rf_wdata;

    logic               csr_en;
    logic               csr_set;
    logic [11:0]        csr_addr;
    logic [63:0]        csr_wdata;
    logic [63:0]        csr_rdata;
    logic               irq_take;
    logic               trap;
    logic [63:0]        trap_pc;
    logic               mret;
    logic [63:0]        mtvec_q;
    logic [63:0]        mepc_q;

    rv_execute execute_i (
        .clk              (clk),
        .reset            (reset),
        .pc               (pc),
        .instruction      (instruction),
        .ir_word          (ir_word),
        .dec_op           (dec_op),
        .dec_rd           (dec_rd),
        .dec_rs1          (dec_rs1),
        .dec_rs2          (dec_rs2),
        .dec_imm          (dec_imm),
        .dec_csr_addr     (dec_csr_addr),
        .rf_rs1           (rf_rs1),
        .rf_rs2           (rf_rs2),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .rf_we            (rf_we),
        .rf_rd            (rf_rd),
        .rf_wdata         (rf_wdata),
        .csr_en           (csr_en),
        .csr_set          (csr_set),
        .csr_addr         (csr_addr),
        .csr_wdata        (csr_wdata),
        .csr_rdata        (csr_rdata),
        .irq_take         (irq_take),
        .trap             (trap),
        .trap_pc          (trap_pc),
        .mret             (mret),
        .mtvec_q          (mtvec_q),
        .mepc_q           (mepc_q),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .interrupt_ack    (interrupt_ack)
    );

    rv_decode decode_i (
        .instr    (ir_word),
        .op       (dec_op),
        .rd       (dec_rd),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .imm      (dec_imm),
        .csr_addr (dec_csr_addr)
    );

    rv_regfile regfile_i (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rf_rs1),
        .rs2      (rf_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (rf_rd),
        .rd_data  (rf_wdata)
    );

    rv_csr_unit csr_unit_i (
        .clk       (clk),
        .reset     (reset),
        .csr_en    (csr_en),
        .csr_set   (csr_set),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .ext_irq   (ext_irq),
        .irq_take  (irq_take),
        .trap      (trap),
        .trap_pc   (trap_pc),
        .mret      (mret),
        .mtvec_q   (mtvec_q),
        .mepc_q    (mepc_q)
    );

endmodule

`default_nettype wire

//--- rv64_checker.sv
`default_nettype none

module rv64_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic [63:0] pc,
    input  logic [63:0] bus_address,
    input  logic [63:0] bus_write_data,
    input  logic        bus_read_enable,
    input  logic        bus_write_enable,
    input  logic        interrupt_ack,
    output int          error_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import rv_csr_pkg::*;

    // architectural model state
    logic [31:0] prog [0:1023];
    logic [63:0] mem [0:31];
    logic [63:0] regs [0:31];
    logic [63:0] mpc;
    logic [63:0] model_mstatus;
    logic [63:0] model_mie;
    logic        ack_prev;
    int          value_errors;
    int          event_errors;
    int          stores_checked;
    int          acks_seen;
    int          mepc_seen;

    assign error_count = value_errors + event_errors;

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i] = 64'd0;
        end
        mpc            = reset_pc;
        model_mstatus  = 64'd0;
        model_mie      = 64'd0;
        ack_prev       = 1'b0;
        value_errors   = 0;
        event_errors   = 0;
        stores_checked = 0;
        acks_seen      = 0;
        mepc_seen      = 0;
    end

    task load_program_word(input logic [63:0] addr, input logic [31:0] word);
        prog[addr[11:2]] = word;
    endtask

    task load_data_word(input logic [63:0] addr, input logic [63:0] data);
        mem[(addr - 64'h1f80) >> 3] = data;
    endtask

    task report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
        value_errors++;
    endtask

    task report_event(input string what);
        $display("Error at %0t: %s", $time, what);
        event_errors++;
    endtask

    function automatic logic in_window(input logic [63:0] a);
        return a >= 64'h1f80 && a < 64'h2080;
    endfunction

    // one instruction of the ISA with csr writes to mstatus and mie tracked
    task automatic step_model(output logic st, output logic [63:0] a, output logic [63:0] d);
        logic [31:0] w;
        logic [4:0]  rd;
        logic [63:0] v1;
        logic [63:0] v2;
        logic [63:0] imm_i;
        logic [63:0] imm_s;
        logic [63:0] res;
        logic        wr;
        w     = prog[mpc[11:2]];
        rd    = w[11:7];
        v1    = regs[w[19:15]];
        v2    = regs[w[24:20]];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
        st    = 1'b0;
        a     = 64'd0;
        d     = 64'd0;
        wr    = 1'b0;
        res   = 64'd0;
        case (w[6:0])
            7'b0110111: begin
                wr  = 1'b1;
                res = {{32{w[31]}}, w[31:12], 12'h000};
            end
            7'b0010011: begin
                wr  = (w[14:12] == 3'b000);
                res = v1 + imm_i;
            end
            7'b0110011: begin
                wr  = (w[14:12] == 3'b000) && (w[31:25] == 7'd0);
                res = v1 + v2;
            end
            7'b0000011: begin
                wr  = 1'b1;
                res = mem[(v1 + imm_i - 64'h1f80) >> 3];
            end
            7'b0100011: begin
                st = 1'b1;
                a  = v1 + imm_s;
                d  = v2;
                if (in_window(a)) begin
                    mem[(a - 64'h1f80) >> 3] = d;
                end
            end
            7'b1110011: begin
                // csrrw replaces the value, csrrs ors rs1 into it
                if (w[14:12] == 3'b001 && w[31:20] == csr_mstatus) begin
                    model_mstatus = v1;
                end else if (w[14:12] == 3'b010 && w[31:20] == csr_mstatus) begin
                    model_mstatus = model_mstatus | v1;
                end else if (w[14:12] == 3'b001 && w[31:20] == csr_mie) begin
                    model_mie = v1;
                end else if (w[14:12] == 3'b010 && w[31:20] == csr_mie) begin
                    model_mie = model_mie | v1;
                end
            end
            default: ;
        endcase
        // x0 stays zero
        if (wr && rd != 5'd0) begin
            regs[rd] = res;
        end
        mpc = mpc + 64'd4;
    endtask

    // retire up to the interrupted instruction with no store in between
    task automatic catch_up(input logic [63:0] target);
        logic        st;
        logic [63:0] a;
        logic [63:0] d;
        int          n;
        n = 0;
        if (target < mpc) begin
            report_value("mepc", mpc, target);
        end else begin
            while (mpc != target && n < 400) begin
                step_model(st, a, d);
                n++;
                if (st) begin
                    report_event("store skipped before the interrupted instruction");
                end
            end
            if (mpc != target) begin
                report_event("mepc never reached by the model");
            end else if (!model_mstatus[mstatus_mie_bit] || !model_mie[mie_meie_bit]) begin
                report_event("interrupt taken while MIE or MEIE was clear");
            end
        end
    endtask

    task automatic next_store();
        logic        st;
        logic [63:0] a;
        logic [63:0] d;
        int          n;
        st = 1'b0;
        n  = 0;
        while (!st && n < 400) begin
            step_model(st, a, d);
            n++;
        end
        if (!st) begin
            report_event("bus write with no store left in the model");
        end else begin
            stores_checked++;
            if (bus_address !== a) begin
                report_value("bus_address", a, bus_address);
            end
            if (bus_write_data !== d) begin
                report_value("bus_write_data", d, bus_write_data);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            // held in reset
            if (pc !== reset_pc) begin
                report_value("pc", reset_pc, pc);
            end
            if (bus_read_enable !== 1'b0 || bus_write_enable !== 1'b0) begin
                report_event("bus strobe active during reset");
            end
            if (interrupt_ack !== 1'b0) begin
                report_event("interrupt_ack active during reset");
            end
        end else begin
            if (interrupt_ack) begin
                if (ack_prev) begin
                    report_event("interrupt_ack held longer than one cycle");
                end
                acks_seen++;
            end
            ack_prev = interrupt_ack;
            if (bus_write_enable) begin
                if (bus_address == 64'hf00) begin
                    if (bus_write_data !== mcause_ext_irq) begin
                        report_value("mcause", mcause_ext_irq, bus_write_data);
                    end
                end else if (bus_address == 64'hf08) begin
                    mepc_seen++;
                    if (mepc_seen != acks_seen) begin
                        report_event("handler entered without a matching interrupt_ack");
                    end
                    catch_up(bus_write_data);
                end else begin
                    next_store();
                end
            end
        end
    end

    task close_report(input int timeouts);
        if (acks_seen != mepc_seen) begin
            report_event("interrupt_ack count differs from handler runs");
        end
        $display("checker: %0d stores, %0d interrupts, %0d value errors, %0d other errors, %0d timeouts",
                 stores_checked, acks_seen, value_errors, event_errors, timeouts);
    endtask

endmodule

`default_nettype wire

//--- tb_rv64_core.sv
`default_nettype none

module tb_rv64_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [63:0] pc;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_read_enable;
    logic        bus_write_enable;
    logic [63:0] bus_read_data;
    logic        ext_irq;
    logic        interrupt_ack;
    int          chk_errors;

    // memories and generator state
    logic [31:0] imem [0:1023];
    logic [63:0] dmem [0:31];
    logic [63:0] rng;
    logic [63:0] gen_pc;
    logic [63:0] prog_end;
    int          tb_errors;

    rv64_core dut_i (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .ext_irq          (ext_irq),
        .interrupt_ack    (interrupt_ack)
    );

    rv64_checker chk_i (
        .clk              (clk),
        .reset            (reset),
        .pc               (pc),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .interrupt_ack    (interrupt_ack),
        .error_count      (chk_errors)
    );

    always #5 clk = ~clk;

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    task next_rand(output logic [31:0] r);
        rng = xorshift(rng);
        r   = rng[31:0];
    endtask

    function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3_sd, imm[4:0], op_store};
    endfunction

    task emit(input logic [31:0] word);
        imem[gen_pc[11:2]] = word;
        chk_i.load_program_word(gen_pc, word);
        gen_pc = gen_pc + 64'd4;
    endtask

    task build_program();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [11:0] off;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = nop_word;
            chk_i.load_program_word(i * 4, nop_word);
        end
        // data window 0x1f80 to 0x207f around the x15 base
        for (int i = 0; i < 32; i++) begin
            dmem[i] = xorshift((64'h1f80 + i * 8) ^ 64'h9e37_79b9_7f4a_7c15);
            chk_i.load_data_word(64'h1f80 + i * 8, dmem[i]);
        end
        gen_pc = reset_pc;
        // mtvec at 0x800 then MIE and MEIE
        emit(enc_u(5'd1, 20'd1));
        emit(enc_i(op_opimm, 3'b000, 5'd1, 5'd1, 12'h800));
        emit(enc_i(op_system, f3_csrrw, 5'd0, 5'd1, csr_mtvec));
        emit(enc_i(op_opimm, 3'b000, 5'd1, 5'd0, 12'd8));
        emit(enc_i(op_system, f3_csrrs, 5'd0, 5'd1, csr_mstatus));
        emit(enc_u(5'd1, 20'd1));
        emit(enc_i(op_opimm, 3'b000, 5'd1, 5'd1, 12'h800));
        emit(enc_i(op_system, f3_csrrs, 5'd0, 5'd1, csr_mie));
        emit(enc_u(5'd15, 20'd2));
        for (int i = 0; i < 200; i++) begin
            next_rand(r);
            next_rand(r2);
            rd  = r2[3:0] % 15;
            off = (r2[12:8] * 8) - 128;
            if (r % 100 < 20) begin
                emit(enc_u(rd, r2[31:12]));
            end else if (r % 100 < 50) begin
                emit(enc_i(op_opimm, 3'b000, rd, r2[7:4], r2[31:20]));
            end else if (r % 100 < 65) begin
                emit({7'd0, 1'b0, r2[23:20], 1'b0, r2[7:4], 3'b000, rd, op_op});
            end else if (r % 100 < 80) begin
                emit(enc_i(op_load, f3_ld, rd, 5'd15, off));
            end else begin
                emit(enc_s({1'b0, r2[7:4]}, 5'd15, off));
            end
        end
        // sentinel store to 0xc00
        emit(enc_u(5'd19, 20'd1));
        emit(enc_s(5'd19, 5'd19, 12'hc00));
        prog_end = gen_pc;
        // handler stores mcause and mepc and returns
        gen_pc = 64'h800;
        emit(enc_i(op_system, f3_csrrs, 5'd16, 5'd0, csr_mcause));
        emit(enc_i(op_system, f3_csrrs, 5'd17, 5'd0, csr_mepc));
        emit(enc_u(5'd18, 20'd1));
        emit(enc_s(5'd16, 5'd18, 12'hf00));
        emit(enc_s(5'd17, 5'd18, 12'hf08));
        emit(mret_word);
    endtask

    // instruction and data memory answer on the falling edge
    always @(negedge clk) begin
        instruction = imem[pc[11:2]];
        if (bus_read_enable) begin
            bus_read_data = dmem[(bus_address - 64'h1f80) >> 3];
        end
        if (bus_write_enable && bus_address >= 64'h1f80 && bus_address < 64'h2080) begin
            dmem[(bus_address - 64'h1f80) >> 3] = bus_write_data;
        end
    end

    initial begin
        logic [31:0] r;
        logic        sentinel_seen;
        logic        handler_busy;
        int          cycles;
        int          irq_wait;
        clk           = 1'b0;
        reset         = 1'b0;
        instruction   = nop_word;
        bus_read_data = 64'd0;
        ext_irq       = 1'b0;
        rng           = 64'd90189;
        tb_errors     = 0;
        sentinel_seen = 1'b0;
        handler_busy  = 1'b0;
        cycles        = 0;
        irq_wait      = 0;
        build_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        while (!sentinel_seen && tb_errors == 0) begin
            @(negedge clk);
            cycles++;
            if (bus_write_enable && bus_address == 64'hc00) begin
                sentinel_seen = 1'b1;
            end
            if (bus_write_enable && bus_address == 64'hf08) begin
                handler_busy = 1'b0;
            end
            if (interrupt_ack) begin
                ext_irq      = 1'b0;
                handler_busy = 1'b1;
                irq_wait     = 0;
            end
            next_rand(r);
            if (ext_irq || handler_busy) begin
                irq_wait++;
                if (irq_wait > 300) begin
                    $display("timeout: interrupt_ack or handler mepc store never came");
                    tb_errors++;
                end
            end else if (pc < prog_end && r % 50 == 0) begin
                ext_irq  = 1'b1;
                irq_wait = 0;
            end
            if (cycles > 20000) begin
                $display("timeout: final sentinel store never came");
                tb_errors++;
            end
        end
        // let the checker finish this edge before the report
        #1;
        chk_i.close_report(tb_errors);
        #1;
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv64_core.f
rv_isa_pkg.sv
rv_csr_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_csr_unit.sv
rv_execute.sv
rv64_core.sv
rv64_checker.sv
tb_rv64_core.sv
